// File: Makefile
# Verilator build and run of the decode front end testbench
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = DecodeFrontEndTb
FILELIST = all.f
BUILD    = obj_dir
PASS_MSG = Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -Fxq "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

// File: all.f
hw/FrontEndPkg.sv
hw/DecodeLaneIf.sv
hw/InsnPreDecoder.sv
hw/ReturnAddressStack.sv
hw/DecodedBranchResolver.sv
hw/DecodeFrontEnd.sv
testbench/DecodeFrontEndTb.sv

// File: hw/DecodeFrontEnd.sv
// --------------------------------------------------------------------
// Decode front end
// Top level of the decode-stage branch check with plain ports
// --------------------------------------------------------------------
`timescale 1ns/1ps

module DecodeFrontEnd
    import FrontEndPkg::*;
(
    input logic clk,
    input logic rst,
    input logic stall,
    input logic decodeComplete,
    input logic insnValid[DECODE_WIDTH],
    input logic [INSN_WIDTH-1:0] insn[DECODE_WIDTH],
    input PcPath pc[DECODE_WIDTH],
    input logic predTaken[DECODE_WIDTH],
    input PcPath predAddr[DECODE_WIDTH],
    output logic insnValidOut[DECODE_WIDTH],
    output logic insnFlushed[DECODE_WIDTH],
    output logic insnFlushTriggering[DECODE_WIDTH],
    output logic flushTriggered,
    output logic outPredTaken[DECODE_WIDTH],
    output PcPath outPredAddr[DECODE_WIDTH],
    output PcPath recoveredPC
);

    DecodeLaneIf lanes();

    InsnInfo info[DECODE_WIDTH];
    BranchPred brPredOut[DECODE_WIDTH];
    PcPath rasTop;
    PcPath rasPushAddr;
    logic rasUpdate;
    logic rasPush;
    logic rasPop;

    // Pack the fetch group and unpack the corrected guesses
    for (genvar i = 0; i < DECODE_WIDTH; i++) begin : gLane
        assign lanes.valid[i] = insnValid[i];
        assign lanes.insn[i] = insn[i];
        assign lanes.pc[i] = pc[i];
        assign lanes.pred[i] = '{predTaken: predTaken[i], predAddr: predAddr[i]};

        assign outPredTaken[i] = brPredOut[i].predTaken;
        assign outPredAddr[i] = brPredOut[i].predAddr;
    end

    InsnPreDecoder preDecoder (
        .lanes(lanes.decode),
        .info (info)
    );

    DecodedBranchResolver resolver (
        .stall              (stall),
        .decodeComplete     (decodeComplete),
        .lanes              (lanes.resolve),
        .info               (info),
        .rasTop             (rasTop),
        .insnValidOut       (insnValidOut),
        .insnFlushed        (insnFlushed),
        .insnFlushTriggering(insnFlushTriggering),
        .flushTriggered     (flushTriggered),
        .brPredOut          (brPredOut),
        .recoveredPC        (recoveredPC),
        .rasUpdate          (rasUpdate),
        .rasPush            (rasPush),
        .rasPop             (rasPop),
        .rasPushAddr        (rasPushAddr)
    );

    ReturnAddressStack ras (
        .clk     (clk),
        .rst     (rst),
        .update  (rasUpdate),
        .push    (rasPush),
        .pop     (rasPop),
        .pushAddr(rasPushAddr),
        .rasTop  (rasTop)
    );

endmodule

// File: hw/DecodeLaneIf.sv
// --------------------------------------------------------------------
// Decode lane bundle
// Carries one decode group from fetch: valid, word, PC and prediction
// --------------------------------------------------------------------
`timescale 1ns/1ps

interface DecodeLaneIf
    import FrontEndPkg::*;
();

    // One entry per lane
    logic valid[DECODE_WIDTH];
    logic [INSN_WIDTH-1:0] insn[DECODE_WIDTH];
    PcPath pc[DECODE_WIDTH];
    BranchPred pred[DECODE_WIDTH];

    // Fetch side fills the whole group
    modport fetch(
        output valid, insn, pc, pred
    );

    // Pre-decoder only looks at the words
    modport decode(
        input insn
    );

    // Resolver needs lane state and the guesses
    modport resolve(
        input valid, pc, pred
    );

endinterface

// File: hw/DecodedBranchResolver.sv
// --------------------------------------------------------------------
// Decoded branch resolver
// Finds the first mispredicted lane of a decode group, drives the
// recovered PC and flush masks, and steers the return address stack
// --------------------------------------------------------------------
`timescale 1ns/1ps

module DecodedBranchResolver
    import FrontEndPkg::*;
(
    input logic stall,
    input logic decodeComplete,
    DecodeLaneIf.resolve lanes,
    input InsnInfo info[DECODE_WIDTH],
    input PcPath rasTop,
    output logic insnValidOut[DECODE_WIDTH],
    output logic insnFlushed[DECODE_WIDTH],
    output logic insnFlushTriggering[DECODE_WIDTH],
    output logic flushTriggered,
    output BranchPred brPredOut[DECODE_WIDTH],
    output PcPath recoveredPC,
    output logic rasUpdate,
    output logic rasPush,
    output logic rasPop,
    output PcPath rasPushAddr
);

    BranchTargetType targetType[DECODE_WIDTH];
    PcPath nextPC[DECODE_WIDTH];
    PcPath decodedPC[DECODE_WIDTH];
    logic addrMismatch[DECODE_WIDTH];

    DecodeLaneIndex checkLane;
    logic addrCheck;
    logic missCertain;
    logic stopScan;

    // Target source and decoded target per lane
    always_comb begin
        for (int i = 0; i < DECODE_WIDTH; i++) begin
            if (info[i].isRelBranch) begin
                targetType[i] = BTT_PC_RELATIVE;
            end else if (info[i].writePC) begin
                targetType[i] = BTT_INDIRECT_JUMP;
            end else if (info[i].isSerialized) begin
                targetType[i] = BTT_SERIALIZED;
            end else begin
                targetType[i] = BTT_NEXT;
            end

            nextPC[i] = lanes.pc[i] + PcPath'(INSN_BYTE_WIDTH);

            case (targetType[i])
                BTT_PC_RELATIVE:   decodedPC[i] = lanes.pc[i] + info[i].disp;
                // Only returns are checked, and they take the stack top
                BTT_INDIRECT_JUMP: decodedPC[i] = rasTop;
                default:           decodedPC[i] = nextPC[i];
            endcase

            addrMismatch[i] = lanes.pred[i].predAddr != decodedPC[i];
        end
    end

    // Scan lanes oldest first, stop at first invalid lane or first event
    always_comb begin
        checkLane = '0;
        addrCheck = 1'b0;
        missCertain = 1'b0;
        stopScan = 1'b0;
        rasPush = 1'b0;
        rasPop = 1'b0;

        for (int i = 0; i < DECODE_WIDTH; i++) begin
            if (!stopScan) begin
                if (!lanes.valid[i]) begin
                    stopScan = 1'b1;
                end else if (!info[i].writePC && !info[i].isRelBranch &&
                             lanes.pred[i].predTaken) begin
                    // Non-branch guessed taken, always wrong
                    checkLane = DecodeLaneIndex'(i);
                    addrCheck = 1'b1;
                    missCertain = 1'b1;
                    stopScan = 1'b1;
                end else if (targetType[i] == BTT_PC_RELATIVE &&
                             (info[i].isJal || lanes.pred[i].predTaken)) begin
                    // JAL or taken branch, compare against pc + disp
                    rasPush = info[i].isCall;
                    checkLane = DecodeLaneIndex'(i);
                    addrCheck = 1'b1;
                    stopScan = 1'b1;
                end else if (targetType[i] == BTT_INDIRECT_JUMP) begin
                    if (info[i].isReturn) begin
                        rasPop = 1'b1;
                        checkLane = DecodeLaneIndex'(i);
                        addrCheck = 1'b1;
                        stopScan = 1'b1;
                    end else if (info[i].isCall) begin
                        // Indirect call target unknown here, push only
                        rasPush = 1'b1;
                        checkLane = DecodeLaneIndex'(i);
                        stopScan = 1'b1;
                    end
                end else if (targetType[i] == BTT_SERIALIZED) begin
                    checkLane = DecodeLaneIndex'(i);
                    addrCheck = 1'b1;
                    missCertain = 1'b1;
                    stopScan = 1'b1;
                end
            end
        end
    end

    assign flushTriggered = addrCheck && (missCertain || addrMismatch[checkLane]);
    assign recoveredPC = decodedPC[checkLane];

    // Kill younger lanes and rewrite the triggering lane's guess
    always_comb begin
        for (int i = 0; i < DECODE_WIDTH; i++) begin
            insnFlushed[i] = flushTriggered && (i > int'(checkLane));
            insnValidOut[i] = lanes.valid[i] && !insnFlushed[i];
            insnFlushTriggering[i] = flushTriggered && (i == int'(checkLane));

            if (insnFlushTriggering[i]) begin
                brPredOut[i].predTaken = 1'b1;
                brPredOut[i].predAddr = decodedPC[i];
            end else begin
                brPredOut[i] = lanes.pred[i];
            end
        end
    end

    // Stack only moves once the whole group has left decode
    assign rasUpdate = decodeComplete && !stall;
    assign rasPushAddr = nextPC[checkLane];

endmodule

// File: hw/FrontEndPkg.sv
// --------------------------------------------------------------------
// Front end package
// Shared widths, opcode and branch target enums, and the prediction
// and pre-decoded instruction records used by the decode stage
// --------------------------------------------------------------------
package FrontEndPkg;

    // Decode group geometry
    localparam int DECODE_WIDTH = 2;
    localparam int PC_WIDTH = 32;
    localparam int INSN_WIDTH = 32;
    localparam int INSN_BYTE_WIDTH = 4;

    // Return address stack depth and pointer width
    localparam int RAS_ENTRY_NUM = 8;
    localparam int RAS_INDEX_WIDTH = $clog2(RAS_ENTRY_NUM);

    typedef logic [PC_WIDTH-1:0] PcPath;
    typedef logic [$clog2(DECODE_WIDTH)-1:0] DecodeLaneIndex;

    // Major opcodes the decode stage cares about
    typedef enum logic [6:0] {
        OP_OTHER    = 7'b0000000,
        OP_JAL      = 7'b1101111,
        OP_JALR     = 7'b1100111,
        OP_BRANCH   = 7'b1100011,
        OP_MISC_MEM = 7'b0001111,
        OP_SYSTEM   = 7'b1110011
    } RiscvOpcode;

    // Where the true next PC of a lane comes from
    typedef enum logic [1:0] {
        BTT_NEXT          = 2'd0,
        BTT_PC_RELATIVE   = 2'd1,
        BTT_INDIRECT_JUMP = 2'd2,
        // Younger lanes are always dropped
        BTT_SERIALIZED    = 2'd3
    } BranchTargetType;

    // Predictor guess for one lane
    typedef struct packed {
        logic predTaken;
        PcPath predAddr;
    } BranchPred;

    // Pre-decoded flags plus sign-extended displacement
    typedef struct packed {
        logic isRelBranch;
        logic isJal;
        logic writePC;
        logic isSerialized;
        logic isCall;
        logic isReturn;
        PcPath disp;
    } InsnInfo;

endpackage

// File: hw/InsnPreDecoder.sv
// --------------------------------------------------------------------
// Instruction pre-decoder
// Classifies each lane's word for the branch resolver and extracts
// the J-type or B-type displacement
// --------------------------------------------------------------------
`timescale 1ns/1ps

module InsnPreDecoder
    import FrontEndPkg::*;
(
    DecodeLaneIf.decode lanes,
    output InsnInfo info[DECODE_WIDTH]
);

    for (genvar i = 0; i < DECODE_WIDTH; i++) begin : gLane
        logic [INSN_WIDTH-1:0] word;
        RiscvOpcode opcode;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic rdLink;
        logic rs1Link;
        PcPath jDisp;
        PcPath bDisp;
        InsnInfo laneInfo;

        assign word = lanes.insn[i];
        assign rd = word[11:7];
        assign rs1 = word[19:15];

        // x1 (ra) and x5 (t0) are the link registers
        assign rdLink = (rd == 5'd1) || (rd == 5'd5);
        assign rs1Link = (rs1 == 5'd1) || (rs1 == 5'd5);

        // J-type immediate, bit 0 always zero
        assign jDisp = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};

        // B-type immediate
        assign bDisp = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};

        // Map the raw major opcode; anything unknown is OP_OTHER
        always_comb begin
            case (word[6:0])
                OP_JAL:      opcode = OP_JAL;
                OP_JALR:     opcode = OP_JALR;
                OP_BRANCH:   opcode = OP_BRANCH;
                OP_MISC_MEM: opcode = OP_MISC_MEM;
                OP_SYSTEM:   opcode = OP_SYSTEM;
                default:     opcode = OP_OTHER;
            endcase
        end

        always_comb begin
            laneInfo = '0;
            laneInfo.isRelBranch = (opcode == OP_JAL) || (opcode == OP_BRANCH);
            laneInfo.isJal = (opcode == OP_JAL);
            // Unconditional jumps only
            laneInfo.writePC = (opcode == OP_JAL) || (opcode == OP_JALR);
            // FENCE, FENCE.I and SYSTEM all drain the younger lanes
            laneInfo.isSerialized = (opcode == OP_MISC_MEM) || (opcode == OP_SYSTEM);
            laneInfo.isCall = ((opcode == OP_JAL) || (opcode == OP_JALR)) && rdLink;
            // jalr x0, 0(ra) style return
            laneInfo.isReturn = (opcode == OP_JALR) && (rd == 5'd0) && rs1Link;

            // Displacement only meaningful for PC-relative kinds
            if (opcode == OP_JAL) begin
                laneInfo.disp = jDisp;
            end else if (opcode == OP_BRANCH) begin
                laneInfo.disp = bDisp;
            end else begin
                laneInfo.disp = '0;
            end
        end

        assign info[i] = laneInfo;
    end

endmodule

// File: hw/ReturnAddressStack.sv
// --------------------------------------------------------------------
// Return address stack
// Circular stack of return addresses; the pointer wraps on overflow
// --------------------------------------------------------------------
`timescale 1ns/1ps

module ReturnAddressStack
    import FrontEndPkg::*;
(
    input logic clk,
    input logic rst,
    input logic update,
    input logic push,
    input logic pop,
    input PcPath pushAddr,
    output PcPath rasTop
);

    PcPath entries[RAS_ENTRY_NUM];
    logic [RAS_INDEX_WIDTH-1:0] ptr;
    logic [RAS_INDEX_WIDTH-1:0] pushPtr;
    logic [RAS_INDEX_WIDTH-1:0] popPtr;

    // Neighbour slots, wrapping silently
    assign pushPtr = ptr + RAS_INDEX_WIDTH'(1);
    assign popPtr = ptr - RAS_INDEX_WIDTH'(1);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < RAS_ENTRY_NUM; i++) begin
                entries[i] <= '0;
            end
            ptr <= '0;
        end else if (update) begin
            // Push wins if both are ever raised
            if (push) begin
                entries[pushPtr] <= pushAddr;
                ptr <= pushPtr;
            end else if (pop) begin
                ptr <= popPtr;
            end
        end
    end

    // Current top, read in the same cycle
    assign rasTop = entries[ptr];

endmodule

// File: testbench/DecodeFrontEndTb.sv
// ----------------------------------------------------------------------
// Decode front end testbench
// Directed and random decode groups checked every cycle against a
// reference model of the branch resolver and its return address stack
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module DecodeFrontEndTb
    import FrontEndPkg::*;
();

    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 10;
    localparam int RANDOM_GROUPS = 300;
    // Directed groups with the idle group after each test, rounded up
    localparam int DIRECTED_GROUPS = 30;
    localparam int TIMEOUT_NS =
        (RESET_CYCLES + DIRECTED_GROUPS + RANDOM_GROUPS + 1) * 40 + 1000;
    localparam logic [31:0] NOP_WORD = 32'h00000013;
    localparam logic [31:0] FENCE_WORD = 32'h0000000f;
    localparam logic [31:0] FENCEI_WORD = 32'h0000100f;
    localparam logic [31:0] ECALL_WORD = 32'h00000073;

    typedef struct packed {
        logic valid;
        logic [31:0] word;
        PcPath pc;
        logic taken;
        PcPath addr;
    } LaneIn;

    typedef struct packed {
        logic flush;
        PcPath recPC;
        logic [DECODE_WIDTH-1:0] validOut;
        logic [DECODE_WIDTH-1:0] flushed;
        logic [DECODE_WIDTH-1:0] trig;
        logic [DECODE_WIDTH-1:0] outTaken;
        logic [DECODE_WIDTH-1:0][31:0] outAddr;
        logic push;
        logic pop;
        PcPath pushAddr;
    } Expect;

    logic clk;
    logic rst;
    logic stall;
    logic decodeComplete;
    logic insnValid[DECODE_WIDTH];
    logic [INSN_WIDTH-1:0] insn[DECODE_WIDTH];
    PcPath pc[DECODE_WIDTH];
    logic predTaken[DECODE_WIDTH];
    PcPath predAddr[DECODE_WIDTH];
    logic insnValidOut[DECODE_WIDTH];
    logic insnFlushed[DECODE_WIDTH];
    logic insnFlushTriggering[DECODE_WIDTH];
    logic flushTriggered;
    logic outPredTaken[DECODE_WIDTH];
    PcPath outPredAddr[DECODE_WIDTH];
    PcPath recoveredPC;

    // Model stack and scoreboard state
    PcPath modelStack[RAS_ENTRY_NUM];
    int modelPtr;
    LaneIn [DECODE_WIDTH-1:0] seenGroup;
    Expect expected;
    LaneIn idle;
    logic checking;
    int errCount;
    int checkCount;
    int testCount;
    int failedTests;
    integer seed;

    DecodeFrontEnd uut (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic LaneIn makeLane(input logic v, input logic [31:0] w, input PcPath p,
                                       input logic t, input PcPath a);
        LaneIn l;
        l.valid = v;
        l.word = w;
        l.pc = p;
        l.taken = t;
        l.addr = a;
        return l;
    endfunction

    // Instruction encoders
    function automatic logic [31:0] jalWord(input logic [4:0] rd, input PcPath d);
        return {d[20], d[10:1], d[11], d[19:12], rd, 7'h6f};
    endfunction

    // BEQ x1, x2
    function automatic logic [31:0] branchWord(input PcPath d);
        return {d[12], d[10:5], 5'd2, 5'd1, 3'b000, d[4:1], d[11], 7'h63};
    endfunction

    function automatic logic [31:0] jalrWord(input logic [4:0] rd, input logic [4:0] rs1);
        return {12'h000, rs1, 3'b000, rd, 7'h67};
    endfunction

    // Expected outputs of one group with lanes walked oldest first
    function automatic Expect resolveRef(input LaneIn [DECODE_WIDTH-1:0] grp,
                                         input PcPath stk[RAS_ENTRY_NUM], input int ptr);
        Expect e;
        logic [31:0] w;
        logic [20:0] jImm;
        logic [12:0] bImm;
        logic rdLink;
        logic isReturn;
        logic done;
        int hit;
        e = '0;
        done = 1'b0;
        hit = -1;
        for (int i = 0; i < DECODE_WIDTH; i++) begin
            w = grp[i].word;
            jImm = {w[31], w[19:12], w[20], w[30:21], 1'b0};
            bImm = {w[31], w[7], w[30:25], w[11:8], 1'b0};
            rdLink = w[11:7] == 5'd1 || w[11:7] == 5'd5;
            // jalr x0 through ra or t0
            isReturn = w[11:7] == 5'd0 && (w[19:15] == 5'd1 || w[19:15] == 5'd5);
            if (done || !grp[i].valid) begin
                done = 1'b1;
            end else if (w[6:0] == 7'h6f || (w[6:0] == 7'h63 && grp[i].taken)) begin
                // Direct target known at decode
                e.recPC = grp[i].pc + ((w[6:0] == 7'h6f) ? {{11{jImm[20]}}, jImm}
                                                         : {{19{bImm[12]}}, bImm});
                e.push = w[6:0] == 7'h6f && rdLink;
                e.pushAddr = grp[i].pc + 32'd4;
                hit = (grp[i].addr != e.recPC) ? i : -1;
                done = 1'b1;
            end else if (w[6:0] == 7'h67 && isReturn) begin
                e.recPC = stk[ptr];
                e.pop = 1'b1;
                hit = (grp[i].addr != e.recPC) ? i : -1;
                done = 1'b1;
            end else if (w[6:0] == 7'h67 && rdLink) begin
                // Indirect call pushes without a target check
                e.push = 1'b1;
                e.pushAddr = grp[i].pc + 32'd4;
                done = 1'b1;
            end else if (w[6:0] != 7'h67 && w[6:0] != 7'h63 &&
                         (grp[i].taken || w[6:0] == 7'h0f || w[6:0] == 7'h73)) begin
                // Taken guess on a non-branch or a serializing instruction
                e.recPC = grp[i].pc + 32'd4;
                hit = i;
                done = 1'b1;
            end
        end
        e.flush = hit >= 0;
        for (int i = 0; i < DECODE_WIDTH; i++) begin
            e.flushed[i] = e.flush && i > hit;
            e.trig[i] = e.flush && i == hit;
            e.validOut[i] = grp[i].valid && !e.flushed[i];
            e.outTaken[i] = e.trig[i] || grp[i].taken;
            e.outAddr[i] = e.trig[i] ? e.recPC : grp[i].addr;
        end
        return e;
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] expVal,
                                  input logic [31:0] gotVal);
        errCount++;
        $display("ERROR t=%0t %s expected %0h got %0h", $time, name, expVal, gotVal);
    endtask

    // Compare 1 ns before each rising edge and advance the model stack
    always begin
        @(posedge clk);
        #(CLK_PERIOD - 1);
        if (checking) begin
            for (int i = 0; i < DECODE_WIDTH; i++) begin
                seenGroup[i] = makeLane(insnValid[i], insn[i], pc[i], predTaken[i], predAddr[i]);
            end
            expected = resolveRef(seenGroup, modelStack, modelPtr);
            checkCount++;
            if (flushTriggered !== expected.flush) begin
                reportMismatch("flushTriggered", 32'(expected.flush), 32'(flushTriggered));
            end
            if (expected.flush && recoveredPC !== expected.recPC) begin
                reportMismatch("recoveredPC", expected.recPC, recoveredPC);
            end
            for (int i = 0; i < DECODE_WIDTH; i++) begin
                if (insnValidOut[i] !== expected.validOut[i]) begin
                    reportMismatch($sformatf("insnValidOut[%0d]", i),
                                   32'(expected.validOut[i]), 32'(insnValidOut[i]));
                end
                if (insnFlushed[i] !== expected.flushed[i]) begin
                    reportMismatch($sformatf("insnFlushed[%0d]", i),
                                   32'(expected.flushed[i]), 32'(insnFlushed[i]));
                end
                if (insnFlushTriggering[i] !== expected.trig[i]) begin
                    reportMismatch($sformatf("insnFlushTriggering[%0d]", i),
                                   32'(expected.trig[i]), 32'(insnFlushTriggering[i]));
                end
                if (outPredTaken[i] !== expected.outTaken[i]) begin
                    reportMismatch($sformatf("outPredTaken[%0d]", i),
                                   32'(expected.outTaken[i]), 32'(outPredTaken[i]));
                end
                if (outPredAddr[i] !== expected.outAddr[i]) begin
                    reportMismatch($sformatf("outPredAddr[%0d]", i),
                                   expected.outAddr[i], outPredAddr[i]);
                end
            end
            // DUT stack moves on the coming edge
            if (decodeComplete && !stall) begin
                if (expected.push) begin
                    modelPtr = (modelPtr + 1) % RAS_ENTRY_NUM;
                    modelStack[modelPtr] = expected.pushAddr;
                end else if (expected.pop) begin
                    modelPtr = (modelPtr + RAS_ENTRY_NUM - 1) % RAS_ENTRY_NUM;
                end
            end
        end
    end

    // Drive one group 1 ns after the edge
    task automatic sendGroup(input LaneIn l0, input LaneIn l1, input logic dc, input logic st);
        LaneIn grp[DECODE_WIDTH];
        grp[0] = l0;
        grp[1] = l1;
        @(posedge clk);
        #1;
        for (int i = 0; i < DECODE_WIDTH; i++) begin
            insnValid[i] = grp[i].valid;
            insn[i] = grp[i].word;
            pc[i] = grp[i].pc;
            predTaken[i] = grp[i].taken;
            predAddr[i] = grp[i].addr;
        end
        decodeComplete = dc;
        stall = st;
    endtask

    // Two valid lanes in a completing group
    task automatic sendPair(input logic [31:0] w0, input logic t0, input PcPath a0,
                            input logic [31:0] w1, input logic t1, input PcPath a1,
                            input PcPath pc0);
        sendGroup(makeLane(1'b1, w0, pc0, t0, a0), makeLane(1'b1, w1, pc0 + 32'd4, t1, a1),
                  1'b1, 1'b0);
    endtask

    task automatic finishTest(input string name, input int startErr);
        sendGroup(idle, idle, 1'b0, 1'b0);
        testCount++;
        if (errCount != startErr) begin
            failedTests++;
        end
        $display("Test %0d %s: %0d errors", testCount, name, errCount - startErr);
    endtask

    task automatic randomLane(input PcPath p, output LaneIn l);
        logic [31:0] r;
        logic [31:0] r2;
        PcPath disp;
        logic [4:0] rd;
        logic [31:0] w;
        r = $random(seed);
        r2 = $random(seed);
        disp = {{20{r2[11]}}, r2[11:1], 1'b0};
        rd = r[7] ? 5'd1 : (r[8] ? 5'd5 : 5'd0);
        case (r[2:0])
            3'd2: w = jalWord(rd, disp);
            3'd3: w = branchWord(disp);
            3'd4: w = jalrWord(5'd0, r[9] ? 5'd1 : 5'd5);
            3'd5: w = jalrWord(rd, 5'd6);
            3'd6: w = r[10] ? FENCE_WORD : FENCEI_WORD;
            3'd7: w = ECALL_WORD;
            default: w = NOP_WORD;
        endcase
        // Guess is right often enough to exercise the no-flush paths
        case (r[13:12])
            2'd0: l = makeLane(r[16:14] != 3'd0, w, p, r[11], p + 32'd4);
            2'd1: l = makeLane(r[16:14] != 3'd0, w, p, r[11], p + disp);
            2'd2: l = makeLane(r[16:14] != 3'd0, w, p, r[11], modelStack[modelPtr]);
            default: l = makeLane(r[16:14] != 3'd0, w, p, r[11], {r2[31:2], 2'b00});
        endcase
    endtask

    initial begin
        LaneIn l0;
        LaneIn l1;
        logic [31:0] r;
        int startErr;
        seed = 15804;
        rst = 1'b1;
        stall = 1'b0;
        decodeComplete = 1'b0;
        checking = 1'b0;
        errCount = 0;
        checkCount = 0;
        testCount = 0;
        failedTests = 0;
        modelPtr = 0;
        for (int i = 0; i < RAS_ENTRY_NUM; i++) begin
            modelStack[i] = '0;
        end
        for (int i = 0; i < DECODE_WIDTH; i++) begin
            insnValid[i] = 1'b0;
            insn[i] = NOP_WORD;
            pc[i] = '0;
            predTaken[i] = 1'b0;
            predAddr[i] = '0;
        end
        idle = makeLane(1'b0, NOP_WORD, 32'h0, 1'b0, 32'h0);
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        checking = 1'b1;

        // Guessed address equals pc+4 so only the taken bit is wrong
        startErr = errCount;
        sendPair(NOP_WORD, 1'b1, 32'h104, NOP_WORD, 1'b0, 32'h0, 32'h100);
        sendPair(NOP_WORD, 1'b0, 32'h0, NOP_WORD, 1'b1, 32'h110, 32'h108);
        finishTest("non-branch predicted taken", startErr);

        startErr = errCount;
        sendPair(jalWord(5'd0, 32'h40), 1'b1, 32'h250, NOP_WORD, 1'b0, 32'h0, 32'h200);
        sendPair(jalWord(5'd0, 32'h40), 1'b1, 32'h240, NOP_WORD, 1'b0, 32'h0, 32'h200);
        sendPair(branchWord(32'hfffffff8), 1'b1, 32'h2f8, NOP_WORD, 1'b0, 32'h0, 32'h300);
        sendPair(branchWord(32'hfffffff8), 1'b1, 32'h400, NOP_WORD, 1'b0, 32'h0, 32'h300);
        sendPair(branchWord(32'h20), 1'b0, 32'h999, branchWord(32'h10), 1'b1, 32'h500, 32'h300);
        finishTest("direct jumps and branches", startErr);

        startErr = errCount;
        sendPair(jalWord(5'd1, 32'h80), 1'b1, 32'h1080, NOP_WORD, 1'b0, 32'h0, 32'h1000);
        sendPair(jalrWord(5'd0, 5'd1), 1'b1, 32'h1004, NOP_WORD, 1'b0, 32'h0, 32'h1080);
        // Nested calls from lane 0, lane 1 and then an indirect jump
        sendPair(jalWord(5'd1, 32'h1000), 1'b1, 32'h3000, NOP_WORD, 1'b0, 32'h0, 32'h2000);
        sendPair(NOP_WORD, 1'b0, 32'h0, jalWord(5'd5, 32'h800), 1'b1, 32'h3804, 32'h3000);
        sendPair(jalrWord(5'd1, 5'd6), 1'b1, 32'h6000, NOP_WORD, 1'b0, 32'h0, 32'h4000);
        sendPair(jalrWord(5'd0, 5'd1), 1'b1, 32'h4004, NOP_WORD, 1'b0, 32'h0, 32'h5000);
        sendPair(jalrWord(5'd0, 5'd5), 1'b1, 32'h3008, NOP_WORD, 1'b0, 32'h0, 32'h5100);
        sendPair(jalrWord(5'd0, 5'd1), 1'b1, 32'h7777, NOP_WORD, 1'b0, 32'h0, 32'h5200);
        finishTest("call and return", startErr);

        // Serializing lanes guess pc+4 and must still flush
        startErr = errCount;
        sendPair(FENCE_WORD, 1'b0, 32'h604, NOP_WORD, 1'b0, 32'h0, 32'h600);
        sendPair(FENCEI_WORD, 1'b0, 32'h614, NOP_WORD, 1'b0, 32'h0, 32'h610);
        sendPair(ECALL_WORD, 1'b0, 32'h624, NOP_WORD, 1'b0, 32'h0, 32'h620);
        sendGroup(makeLane(1'b0, ECALL_WORD, 32'h700, 1'b1, 32'h0),
                  makeLane(1'b1, NOP_WORD, 32'h704, 1'b1, 32'h900), 1'b1, 1'b0);
        finishTest("serializing and invalid lanes", startErr);

        startErr = errCount;
        l0 = makeLane(1'b1, jalWord(5'd1, 32'h100), 32'h8000, 1'b1, 32'h8100);
        sendGroup(l0, idle, 1'b1, 1'b1);
        sendGroup(l0, idle, 1'b1, 1'b1);
        sendGroup(l0, idle, 1'b0, 1'b0);
        // Stack untouched so this guess misses
        sendPair(jalrWord(5'd0, 5'd1), 1'b1, 32'h8004, NOP_WORD, 1'b0, 32'h0, 32'h8100);
        finishTest("stall and incomplete group", startErr);

        startErr = errCount;
        for (int n = 0; n < RANDOM_GROUPS; n++) begin
            r = $random(seed);
            randomLane({16'h0001, r[15:2], 2'b00}, l0);
            randomLane({16'h0001, r[15:2], 2'b00} + 32'd4, l1);
            sendGroup(l0, l1, r[19:16] != 4'd0, r[23:20] == 4'd0);
        end
        finishTest("random groups", startErr);

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 testCount, failedTests, checkCount, errCount);
        if (errCount == 0 && checkCount > 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not complete within %0d ns", TIMEOUT_NS);
        $display("Finished with errors");
        $finish;
    end

endmodule
